// ==== tetris_io.f ====
hw/tetris_io_pkg.sv
hw/rom_loader.sv
hw/rom_store.sv
hw/key_mapper.sv
hw/tetris_io_top.sv
dv/tetris_io_assert.sv
dv/tb_tetris_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tetris_io testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
	--top-module tb_tetris_io \
	-f tetris_io.f \
	-o sim_tetris_io

./obj_dir/sim_tetris_io | tee "$LOG"

if grep -q "^PASS: all tests$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

// ==== dv/tb_tetris_io.sv ====
`timescale 1ns/1ps

module tb_tetris_io import tetris_io_pkg::*; ();

	localparam logic [1:0] CHK_NONE = 2'd0;
	localparam logic [1:0] CHK_PROG = 2'd1;
	localparam logic [1:0] CHK_GFX  = 2'd2;

	// key model bit order
	localparam int K_DOWN  = 0;
	localparam int K_LEFT  = 1;
	localparam int K_RIGHT = 2;
	localparam int K_COIN  = 3;
	localparam int K_FIRE  = 4;

	logic                    clk_sd;
	logic                    rst;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [IOCTL_AW-1:0]     ioctl_addr;
	logic [7:0]              ioctl_dout;
	logic                    reset_req;
	logic                    key_strobe;
	logic                    key_pressed;
	logic [7:0]              key_code;
	logic [7:0]              joystick_0;
	logic [7:0]              joystick_1;
	logic                    service_sw;
	logic [PROG_BYTE_AW-1:0] prog_addr;
	logic [WORD_AW-1:0]      gfx_addr;
	logic [7:0]              prog_data;
	logic [15:0]             gfx_data;
	logic                    core_reset;
	logic [INP_W-1:0]        inp;

	logic [7:0]         prog_model [65536];
	logic [7:0]         gfx_model  [65536];
	logic [1:0]         rd_kind;
	logic [1:0]         chk_kind;
	logic [15:0]        chk_prog;
	logic [14:0]        chk_gfx;
	logic               req_q;
	logic [4:0]         held;
	logic [1:0]         cr_mode; // 0 off, 1 high, 2 follows reset_req
	logic               inp_chk;
	integer             seed;
	int                 checks;
	int                 errors;
	int                 ntests;
	int                 chk0;
	int                 err0;
	string              test_name;

	tetris_io_top i_tetris_io_top (
		.clk_sd         (clk_sd),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_req      (reset_req),
		.key_strobe     (key_strobe),
		.key_pressed    (key_pressed),
		.key_code       (key_code),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.service_sw     (service_sw),
		.prog_addr      (prog_addr),
		.gfx_addr       (gfx_addr),
		.prog_data      (prog_data),
		.gfx_data       (gfx_data),
		.core_reset     (core_reset),
		.inp            (inp)
	);

	initial begin
		clk_sd = 1'b0;
		forever #20 clk_sd = ~clk_sd;
	end

	function automatic logic [7:0] prog_byte_of(input logic [15:0] a);
		return prog_model[a];
	endfunction

	// odd byte is the hi half
	function automatic logic [15:0] gfx_word_of(input logic [14:0] w);
		return {gfx_model[{w, 1'b1}], gfx_model[{w, 1'b0}]};
	endfunction

	function automatic logic [INP_W-1:0] expected_inp(input logic [4:0] keys,
			input logic [7:0] j0, input logic [7:0] j1, input logic svc);
		logic [INP_W-1:0] w;
		w = '0;
		w[INP_FIRE1]   = keys[K_FIRE] | j0[JOY_FIRE];
		w[INP_DOWN1]   = keys[K_DOWN] | j0[JOY_DOWN];
		w[INP_RIGHT1]  = keys[K_RIGHT] | j0[JOY_RIGHT];
		w[INP_LEFT1]   = keys[K_LEFT] | j0[JOY_LEFT];
		w[INP_FIRE2]   = j1[JOY_FIRE];
		w[INP_DOWN2]   = j1[JOY_DOWN];
		w[INP_RIGHT2]  = j1[JOY_RIGHT];
		w[INP_LEFT2]   = j1[JOY_LEFT];
		w[INP_COIN]    = keys[K_COIN];
		w[INP_FIXED]   = 1'b1;
		w[INP_SERVICE] = svc;
		return ~w;
	endfunction

	function automatic logic [4:0] key_update(input logic [4:0] keys, input logic [7:0] code,
			input logic pressed);
		logic [4:0] k;
		k = keys;
		case (code)
			KEY_DOWN:  k[K_DOWN]  = pressed;
			KEY_LEFT:  k[K_LEFT]  = pressed;
			KEY_RIGHT: k[K_RIGHT] = pressed;
			KEY_COIN:  k[K_COIN]  = pressed;
			KEY_FIRE:  k[K_FIRE]  = pressed;
			default: ;
		endcase
		return k;
	endfunction

	// first five mapped, the rest not
	function automatic logic [7:0] code_at(input int idx);
		case (idx)
			0: return KEY_DOWN;
			1: return KEY_LEFT;
			2: return KEY_RIGHT;
			3: return KEY_COIN;
			4: return KEY_FIRE;
			5: return 8'h1c;
			6: return 8'h5a;
			7: return 8'hf0;
			default: return 8'h00;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [15:0] exp,
			input logic [15:0] act);
		checks++;
		assert (act === exp)
		else begin
			$display("Mismatch %s: %s expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// capture what the DUT sampled at this edge
	always @(posedge clk_sd) begin
		chk_kind <= rd_kind;
		chk_prog <= prog_addr;
		chk_gfx  <= gfx_addr;
		req_q    <= reset_req;
		if (rst)
			held <= '0;
		else if (key_strobe)
			held <= key_update(held, key_code, key_pressed);
	end

	always @(negedge clk_sd) begin
		if (chk_kind == CHK_PROG)
			check_value("prog_data", {8'h00, prog_byte_of(chk_prog)}, {8'h00, prog_data});
		if (chk_kind == CHK_GFX)
			check_value("gfx_data", gfx_word_of(chk_gfx), gfx_data);
		if (cr_mode == 2'd1)
			check_value("core_reset", 16'h0001, {15'b0, core_reset});
		if (cr_mode == 2'd2)
			check_value("core_reset", {15'b0, req_q}, {15'b0, core_reset});
		if (inp_chk)
			check_value("inp", {5'b0, expected_inp(held, joystick_0, joystick_1, service_sw)},
				{5'b0, inp});
	end

	task automatic dl_write(input logic [IOCTL_AW-1:0] a, input logic [7:0] d, input int hold);
		@(posedge clk_sd);
		ioctl_addr <= a;
		ioctl_dout <= d;
		ioctl_wr   <= 1'b1;
		repeat (hold) @(posedge clk_sd);
		ioctl_wr <= 1'b0;
		repeat (2) @(posedge clk_sd);
	endtask

	task automatic read_prog(input logic [15:0] a);
		@(posedge clk_sd);
		prog_addr <= a;
		rd_kind   <= CHK_PROG;
	endtask

	task automatic fetch_gfx_word(input logic [14:0] w);
		@(posedge clk_sd);
		gfx_addr <= w;
		rd_kind  <= CHK_GFX;
	endtask

	task automatic drain_reads();
		@(posedge clk_sd);
		rd_kind <= CHK_NONE;
		repeat (2) @(posedge clk_sd);
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(posedge clk_sd);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= pressed;
		@(posedge clk_sd);
		key_strobe <= 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		chk0      = checks;
		err0      = errors;
	endtask

	task automatic end_test();
		ntests++;
		$display("test %-10s done: %0d checks, %0d errors", test_name, checks - chk0,
			errors - err0);
	endtask

	task automatic finish_run();
		$display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	endtask

	initial begin
		int          i;
		int          n;
		int          base;
		int          gbase;
		int          nw;
		int          idx;
		int          edges;
		int          fall_edges;
		logic [15:0] a;
		logic [14:0] w;
		logic [7:0]  d;

		seed           = 32'hff08_7ef2;
		checks         = 0;
		errors         = 0;
		ntests         = 0;
		rst            = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		reset_req      = 1'b0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		service_sw     = 1'b0;
		prog_addr      = '0;
		gfx_addr       = '0;
		rd_kind        = CHK_NONE;
		cr_mode        = 2'd0;
		inp_chk        = 1'b0;

		repeat (8) @(posedge clk_sd);
		rst <= 1'b0;

		start_test("idle");
		@(posedge clk_sd);
		cr_mode <= 2'd1;
		inp_chk <= 1'b1;
		repeat (50) @(posedge clk_sd);
		@(negedge clk_sd);
		check_value("inp idle", {5'b0, ~(11'b1 << INP_FIXED)}, {5'b0, inp});
		end_test();

		start_test("prog_image");
		@(posedge clk_sd);
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sd);
		base = $random(seed) & 32'h0000_effe;
		n    = 300 + ($random(seed) & 63);
		for (i = 0; i < n; i++) begin
			a = 16'(base + i);
			d = 8'($random(seed));
			dl_write({1'b0, a}, d, 2);
			prog_model[a] = d;
		end
		@(posedge clk_sd);
		ioctl_download <= 1'b0;
		cr_mode        <= 2'd0;
		@(posedge clk_sd); // first edge that sees the download low
		edges = 0;
		@(negedge clk_sd);
		while (core_reset === 1'b1 && edges < 20) begin
			@(posedge clk_sd);
			edges++;
			@(negedge clk_sd);
		end
		if (core_reset !== 1'b0) begin
			$display("timeout: core_reset still high 20 cycles after the download ended");
			errors++;
			finish_run();
		end
		fall_edges = edges;
		cr_mode <= 2'd2;
		for (i = 0; i < n; i++)
			read_prog(16'(base + i));
		drain_reads();
		end_test();

		start_test("gfx_image");
		@(posedge clk_sd);
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sd);
		gbase = $random(seed) & 32'h0000_3fc0;
		nw    = 64 + ($random(seed) & 63);
		for (i = 0; i < nw; i++) begin
			w = 15'(gbase + i);
			d = 8'($random(seed));
			dl_write({1'b1, w, 1'b0}, d, 2);
			gfx_model[{w, 1'b0}] = d;
			d = 8'($random(seed));
			dl_write({1'b1, w, 1'b1}, d, 2);
			gfx_model[{w, 1'b1}] = d;
		end
		// long strobe lands once
		w = 15'(gbase);
		d = 8'($random(seed));
		dl_write({1'b1, w, 1'b0}, d, 6);
		gfx_model[{w, 1'b0}] = d;
		@(posedge clk_sd);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sd);
		w = 15'(gbase + 1);
		dl_write({1'b1, w, 1'b1}, ~gfx_model[{w, 1'b1}], 2); // no download, ignored
		for (i = 0; i < nw; i++)
			fetch_gfx_word(15'(gbase + i));
		drain_reads();
		end_test();

		start_test("core_reset");
		check_value("release edges", 16'(2), 16'(fall_edges));
		for (i = 0; i < 40; i++) begin
			@(posedge clk_sd);
			reset_req <= 1'($random(seed));
		end
		@(posedge clk_sd);
		reset_req <= 1'b0;
		repeat (2) @(posedge clk_sd);
		end_test();

		start_test("keys");
		for (i = 0; i < 80; i++) begin
			idx = $unsigned($random(seed)) % 9;
			send_key(code_at(idx), 1'($random(seed)));
		end
		repeat (2) @(posedge clk_sd);
		end_test();

		start_test("joystick");
		send_key(KEY_FIRE, 1'b1);
		send_key(KEY_LEFT, 1'b1);
		for (i = 0; i < 60; i++) begin
			@(posedge clk_sd);
			joystick_0 <= 8'($random(seed));
			joystick_1 <= 8'($random(seed));
			service_sw <= 1'($random(seed));
			if (i % 8 == 7) begin
				idx = $unsigned($random(seed)) % 5;
				send_key(code_at(idx), 1'($random(seed)));
			end
		end
		@(posedge clk_sd);
		joystick_0 <= '0;
		joystick_1 <= '0;
		service_sw <= 1'b0;
		repeat (2) @(posedge clk_sd);
		end_test();

		finish_run();
	end

endmodule

// ==== dv/tetris_io_assert.sv ====
`timescale 1ns/1ps

module tetris_io_assert (
	input logic clk_sd,
	input logic rst,
	input logic ioctl_download,
	input logic wr_prog,
	input logic wr_gfx,
	input logic loaded,
	input logic core_reset
);

	// strobe comes two edges after the sampled write
	assert property (@(posedge clk_sd) disable iff (rst)
		(wr_prog || wr_gfx) |-> $past(ioctl_download, 2))
	else $error("store write strobe outside a download");

	assert property (@(posedge clk_sd) disable iff (rst)
		!(wr_prog && wr_gfx))
	else $error("program and graphics write strobes high together");

	assert property (@(posedge clk_sd) disable iff (rst)
		!loaded |=> core_reset)
	else $error("core_reset low while no image is loaded");

endmodule

bind rom_loader tetris_io_assert i_tetris_io_assert (
	.clk_sd         (clk_sd),
	.rst            (rst),
	.ioctl_download (ioctl_download),
	.wr_prog        (wr_prog),
	.wr_gfx         (wr_gfx),
	.loaded         (loaded),
	.core_reset     (core_reset)
);

// ==== hw/tetris_io_top.sv ====
`timescale 1ns/1ps

module tetris_io_top import tetris_io_pkg::*; (
	input  logic                    clk_sd,
	input  logic                    rst,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [IOCTL_AW-1:0]     ioctl_addr,
	input  logic [7:0]              ioctl_dout,
	input  logic                    reset_req,
	input  logic                    key_strobe,
	input  logic                    key_pressed,
	input  logic [7:0]              key_code,
	input  logic [7:0]              joystick_0,
	input  logic [7:0]              joystick_1,
	input  logic                    service_sw,
	input  logic [PROG_BYTE_AW-1:0] prog_addr,
	input  logic [WORD_AW-1:0]      gfx_addr,
	output logic [7:0]              prog_data,
	output logic [15:0]             gfx_data,
	output logic                    core_reset,
	output logic [INP_W-1:0]        inp
);

	logic               wr_prog;
	logic               wr_gfx;
	logic [WORD_AW-1:0] wr_addr;
	logic [1:0]         wr_lane;
	logic [7:0]         wr_byte;

	rom_loader i_rom_loader (
		.clk_sd         (clk_sd),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_req      (reset_req),
		.wr_prog        (wr_prog),
		.wr_gfx         (wr_gfx),
		.wr_addr        (wr_addr),
		.wr_lane        (wr_lane),
		.wr_byte        (wr_byte),
		.core_reset     (core_reset)
	);

	// stands in for the sdram
	rom_store i_rom_store (
		.clk_sd    (clk_sd),
		.wr_prog   (wr_prog),
		.wr_gfx    (wr_gfx),
		.wr_addr   (wr_addr),
		.wr_lane   (wr_lane),
		.wr_byte   (wr_byte),
		.prog_addr (prog_addr),
		.gfx_addr  (gfx_addr),
		.prog_data (prog_data),
		.gfx_data  (gfx_data)
	);

	key_mapper i_key_mapper (
		.clk_sd      (clk_sd),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.service_sw  (service_sw),
		.inp         (inp)
	);

endmodule

// ==== hw/key_mapper.sv ====
`timescale 1ns/1ps

module key_mapper import tetris_io_pkg::*; (
	input  logic             clk_sd,
	input  logic             rst,
	input  logic             key_strobe,
	input  logic             key_pressed,
	input  logic [7:0]       key_code,
	input  logic [7:0]       joystick_0,
	input  logic [7:0]       joystick_1,
	input  logic             service_sw,
	output logic [INP_W-1:0] inp
);

	logic             btn_down;
	logic             btn_left;
	logic             btn_right;
	logic             btn_coin;
	logic             btn_fire;
	logic [INP_W-1:0] act;

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			btn_down  <= 1'b0;
			btn_left  <= 1'b0;
			btn_right <= 1'b0;
			btn_coin  <= 1'b0;
			btn_fire  <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_DOWN:  btn_down  <= key_pressed;
				KEY_LEFT:  btn_left  <= key_pressed;
				KEY_RIGHT: btn_right <= key_pressed;
				KEY_COIN:  btn_coin  <= key_pressed;
				KEY_FIRE:  btn_fire  <= key_pressed;
				default: ; // other codes ignored
			endcase
		end
	end

	always_comb begin
		act = '0;

		// player 1, keyboard or first stick
		act[INP_FIRE1]  = btn_fire | joystick_0[JOY_FIRE];
		act[INP_DOWN1]  = btn_down | joystick_0[JOY_DOWN];
		act[INP_RIGHT1] = btn_right | joystick_0[JOY_RIGHT];
		act[INP_LEFT1]  = btn_left | joystick_0[JOY_LEFT];

		// player 2 has no keys
		act[INP_FIRE2]  = joystick_1[JOY_FIRE];
		act[INP_DOWN2]  = joystick_1[JOY_DOWN];
		act[INP_RIGHT2] = joystick_1[JOY_RIGHT];
		act[INP_LEFT2]  = joystick_1[JOY_LEFT];

		act[INP_COIN]    = btn_coin;
		act[INP_FIXED]   = 1'b1;
		act[INP_SERVICE] = service_sw;
	end

	assign inp = ~act; // core expects negative logic

endmodule

// ==== hw/rom_store.sv ====
`timescale 1ns/1ps

module rom_store import tetris_io_pkg::*; (
	input  logic                    clk_sd,
	input  logic                    wr_prog,
	input  logic                    wr_gfx,
	input  logic [WORD_AW-1:0]      wr_addr,
	input  logic [1:0]              wr_lane,
	input  logic [7:0]              wr_byte,
	input  logic [PROG_BYTE_AW-1:0] prog_addr,
	input  logic [WORD_AW-1:0]      gfx_addr,
	output logic [7:0]              prog_data,
	output logic [15:0]             gfx_data
);

	store_word_u prog_mem [2**WORD_AW];
	store_word_u gfx_mem  [2**WORD_AW];
	store_word_u prog_q;
	store_word_u gfx_q;
	logic        prog_odd;

	// byte lane writes
	always_ff @(posedge clk_sd) begin
		if (wr_prog) begin
			if (wr_lane[1])
				prog_mem[wr_addr].lanes.hi <= wr_byte;
			if (wr_lane[0])
				prog_mem[wr_addr].lanes.lo <= wr_byte;
		end
	end

	always_ff @(posedge clk_sd) begin
		if (wr_gfx) begin
			if (wr_lane[1])
				gfx_mem[wr_addr].lanes.hi <= wr_byte;
			if (wr_lane[0])
				gfx_mem[wr_addr].lanes.lo <= wr_byte;
		end
	end

	// cpu side, byte wide
	always_ff @(posedge clk_sd) begin
		prog_q   <= prog_mem[prog_addr[PROG_BYTE_AW-1:1]];
		prog_odd <= prog_addr[0];
	end

	assign prog_data = prog_odd ? prog_q.lanes.hi : prog_q.lanes.lo;

	// graphics side, whole word
	always_ff @(posedge clk_sd) begin
		gfx_q <= gfx_mem[gfx_addr];
	end

	assign gfx_data = gfx_q.half;

endmodule

// ==== hw/rom_loader.sv ====
`timescale 1ns/1ps

module rom_loader import tetris_io_pkg::*; (
	input  logic                clk_sd,
	input  logic                rst,
	input  logic                ioctl_download,
	input  logic                ioctl_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  logic                reset_req,
	output logic                wr_prog,
	output logic                wr_gfx,
	output logic [WORD_AW-1:0]  wr_addr,
	output logic [1:0]          wr_lane,
	output logic [7:0]          wr_byte,
	output logic                core_reset
);

	logic                wr_d;
	logic                wr_dd;
	logic                dl_d;
	logic                dl_dd;
	logic [IOCTL_AW-1:0] addr_d;
	logic [7:0]          dout_d;
	logic                loaded;
	logic                wr_rise;
	logic                dl_fall;

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			wr_d  <= 1'b0;
			wr_dd <= 1'b0;
			dl_d  <= 1'b0;
			dl_dd <= 1'b0;
		end else begin
			wr_d  <= ioctl_wr;
			wr_dd <= wr_d;
			dl_d  <= ioctl_download;
			dl_dd <= dl_d;
		end
	end

	// sampled together with wr_d
	always_ff @(posedge clk_sd) begin
		addr_d <= ioctl_addr;
		dout_d <= ioctl_dout;
	end

	assign wr_rise = wr_d & ~wr_dd & dl_d; // held strobe counts once
	assign dl_fall = dl_dd & ~dl_d;

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			wr_prog <= 1'b0;
			wr_gfx  <= 1'b0;
		end else begin
			wr_prog <= wr_rise & ~addr_d[IOCTL_AW-1];
			wr_gfx  <= wr_rise & addr_d[IOCTL_AW-1];
		end
	end

	always_ff @(posedge clk_sd) begin
		if (wr_rise) begin
			wr_addr <= addr_d[WORD_AW:1];
			wr_lane <= addr_d[0] ? 2'b10 : 2'b01; // odd byte is hi
			wr_byte <= dout_d;
		end
	end

	// core held in reset until an image has been loaded
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			loaded     <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			if (dl_fall)
				loaded <= 1'b1;
			core_reset <= reset_req | ~loaded;
		end
	end

endmodule

// ==== hw/tetris_io_pkg.sv ====
package tetris_io_pkg;

	// download byte address: bit 16 region, 15:1 word, 0 lane
	localparam int IOCTL_AW     = 17;
	localparam int WORD_AW      = 15;
	localparam int PROG_BYTE_AW = 16;

	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6b;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_COIN  = 8'h76; // esc
	localparam logic [7:0] KEY_FIRE  = 8'h29; // space

	// control word, active form before inversion
	localparam int INP_W       = 11;
	localparam int INP_FIRE1   = 0;
	localparam int INP_DOWN1   = 1;
	localparam int INP_RIGHT1  = 2;
	localparam int INP_LEFT1   = 3;
	localparam int INP_FIRE2   = 4;
	localparam int INP_DOWN2   = 5;
	localparam int INP_RIGHT2  = 6;
	localparam int INP_LEFT2   = 7;
	localparam int INP_COIN    = 8;
	localparam int INP_FIXED   = 9;
	localparam int INP_SERVICE = 10;

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_FIRE  = 4;

	typedef union packed {
		logic [15:0] half;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} lanes;
	} store_word_u;

endpackage
